/* tlb_consts.svh */
// Cache geometry and timing constants, included by the package and the testbench
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// ==================================================
// Geometry
// ==================================================

// Number of sets and the width of a set index
`define TLB_SETS 64
`define TLB_IDX_BITS 6

// Associativity and the width of a way number
`define TLB_WAYS 4
`define TLB_WAY_BITS 2

// Page number widths, all in the cache's own page size
`define TLB_VA_PAGE_BITS 20
`define TLB_PA_PAGE_BITS 20

// Virtual page bits left above the set index
`define TLB_TAG_BITS 14

// ==================================================
// Timing
// ==================================================

// Depth of the recent fill history
`define TLB_HIST_ENTRIES 4

// Cycles from a sampled lookup to its hit or miss pulse
`define TLB_LOOKUP_LATENCY 6

// Cycles from a flush pulse to the start of the sweep
`define TLB_FLUSH_DELAY 2

`endif

/* tlb_pkg.sv */
// Shared types of the translation cache, imported by every RTL module and the testbench
`default_nettype none

`include "tlb_consts.svh"

package tlb_pkg;

    // Page numbers. The low TLB_IDX_BITS of a virtual page select the set
    typedef logic [`TLB_VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [`TLB_PA_PAGE_BITS-1:0] t_pa_page;

    typedef logic [`TLB_IDX_BITS-1:0] t_set_idx;
    typedef logic [`TLB_TAG_BITS-1:0] t_va_tag;

    // One bit per way, and a way number
    typedef logic [`TLB_WAYS-1:0] t_way_vec;
    typedef logic [`TLB_WAY_BITS-1:0] t_way_idx;

    // One stored translation. An all-zero entry is invalid
    typedef struct packed
    {
        logic     valid;
        t_va_tag  tag;
        t_pa_page pa;
    } t_tlb_entry;

    // Fill path states, in the order a fill walks through them
    typedef enum logic [2:0]
    {
        FILL_IDLE,
        FILL_CHECK_HISTORY,
        FILL_DROP_DUPS,
        FILL_PICK_WAY,
        FILL_INSERT
    } t_fill_state;

endpackage

`default_nettype wire

/* tlb_way_ram.sv */
// One way of translation storage, instantiated once per way by the cache top level
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_way_ram
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  t_set_idx  waddr,
    input  wire logic wen,
    input  t_tlb_entry wdata,
    input  t_set_idx  raddr,
    output t_tlb_entry rdata
);

    // Entry array. The maintenance sweep makes every entry invalid after reset
    t_tlb_entry mem [`TLB_SETS];

    // Read address register, first of the two read cycles
    t_set_idx raddr_q;

    always_ff @(posedge clk)
    begin
        // A write and a read of the same set on one edge return the old entry
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        raddr_q <= raddr;

        // Output register, so data follows the address by two edges
        rdata <= mem[raddr_q];
    end

endmodule

`default_nettype wire

/* tlb_dup_filter.sv */
// Short history of recent fills that flags a fill request for a page just inserted
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_dup_filter
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic clear,
    input  wire logic check_en,
    input  t_set_idx  check_idx,
    input  t_va_tag   check_tag,
    output logic      not_duplicate
);

    // Entry 0 is the newest
    logic [`TLB_HIST_ENTRIES-1:0] hist_valid;
    t_set_idx hist_idx [`TLB_HIST_ENTRIES];
    t_va_tag  hist_tag [`TLB_HIST_ENTRIES];

    // Request kept for the history update one edge later
    logic     check_q;
    t_set_idx check_idx_q;
    t_va_tag  check_tag_q;

    logic found;

    always_comb
    begin
        found = 1'b0;
        for (int i = 0; i < `TLB_HIST_ENTRIES; i++)
        begin
            found |= hist_valid[i] && (hist_idx[i] == check_idx) && (hist_tag[i] == check_tag);
        end
    end

    always_ff @(posedge clk)
    begin
        check_idx_q <= check_idx;
        check_tag_q <= check_tag;

        // Payload shifts with the valid bits
        if (check_q && not_duplicate)
        begin
            hist_idx[0] <= check_idx_q;
            hist_tag[0] <= check_tag_q;
            for (int i = 1; i < `TLB_HIST_ENTRIES; i++)
            begin
                hist_idx[i] <= hist_idx[i-1];
                hist_tag[i] <= hist_tag[i-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            hist_valid    <= '0;
            check_q       <= 1'b0;
            not_duplicate <= 1'b0;
        end
        else
        begin
            check_q       <= check_en;
            not_duplicate <= ~found;

            if (check_q && not_duplicate)
            begin
                // Older entries of the same set may name the way just replaced
                hist_valid[0] <= 1'b1;
                for (int i = 1; i < `TLB_HIST_ENTRIES; i++)
                begin
                    hist_valid[i] <= hist_valid[i-1] && (hist_idx[i-1] != check_idx_q);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tlb_maint.sv */
// Flush, page invalidate and insert arbitration for the shared way write port
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_maint
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic flush_tlb,
    input  wire logic inval_page_en,
    input  t_va_page  inval_page_va,
    input  wire logic ins_en,
    input  t_set_idx  ins_idx,
    input  t_va_tag   ins_tag,
    input  t_pa_page  ins_pa,
    input  t_way_vec  ins_way_vec,
    output logic      lookup_ready,
    output logic      hist_clear,
    output t_set_idx  waddr,
    output t_tlb_entry wdata,
    output t_way_vec  wen
);

    // ==================================================
    // Flush request and sweep counter
    // ==================================================

    // Flush pulses travel down this register before the sweep starts
    logic [`TLB_FLUSH_DELAY-1:0] flush_dly;

    logic     sweep_active;
    t_set_idx sweep_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Reset starts a sweep too, since the memories power up unknown
            flush_dly    <= '0;
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
            hist_clear   <= 1'b0;
        end
        else
        begin
            flush_dly  <= {flush_dly[`TLB_FLUSH_DELAY-2:0], flush_tlb};
            hist_clear <= flush_tlb | inval_page_en;

            // A flush during a sweep restarts it from set 0
            if (flush_dly[`TLB_FLUSH_DELAY-1])
            begin
                sweep_active <= 1'b1;
                sweep_idx    <= '0;
            end
            else if (sweep_active)
            begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == t_set_idx'(`TLB_SETS-1))
                begin
                    sweep_active <= 1'b0;
                end
            end
        end
    end

    // Lookups are meaningless while entries are being cleared
    assign lookup_ready = ~sweep_active;

    // ==================================================
    // Write port, sweep then invalidate then insert
    // ==================================================

    // Address and data are payload and follow the winning source
    always_ff @(posedge clk)
    begin
        if (sweep_active)
        begin
            waddr <= sweep_idx;
            wdata <= '0;
        end
        else if (inval_page_en)
        begin
            // The whole set goes, whichever way holds the page
            waddr <= t_set_idx'(inval_page_va);
            wdata <= '0;
        end
        else
        begin
            waddr       <= ins_idx;
            wdata.valid <= 1'b1;
            wdata.tag   <= ins_tag;
            wdata.pa    <= ins_pa;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen <= '0;
        end
        else if (sweep_active || inval_page_en)
        begin
            wen <= '1;
        end
        else if (ins_en)
        begin
            // Only the victim way is written
            wen <= ins_way_vec;
        end
        else
        begin
            wen <= '0;
        end
    end

endmodule

`default_nettype wire

/* tlb_lookup_pipe.sv */
// Lookup pipeline that compares the read ways against the wanted tag and answers hit or miss
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_lookup_pipe
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic lookup_en,
    input  t_va_page  lookup_page_va,
    input  t_tlb_entry rdata [`TLB_WAYS],
    output logic      lookup_hit,
    output logic      lookup_miss,
    output t_pa_page  lookup_page_pa,
    output t_va_page  lookup_miss_va
);

    // ==================================================
    // Request state down the stages
    // ==================================================

    // Stage s holds the lookup sampled s edges earlier
    logic     stg_valid [0:4];
    t_va_page stg_va    [0:5];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s <= 4; s++)
            begin
                stg_valid[s] <= 1'b0;
            end
        end
        else
        begin
            stg_valid[0] <= lookup_en;
            for (int s = 1; s <= 4; s++)
            begin
                stg_valid[s] <= stg_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stg_va[0] <= lookup_page_va;
        for (int s = 1; s <= 5; s++)
        begin
            stg_va[s] <= stg_va[s-1];
        end
    end

    // ==================================================
    // Tag comparison
    // ==================================================

    // Stage 2 copies the way data, which the RAMs return during stage 1
    t_tlb_entry s2_rdata [`TLB_WAYS];

    // Stage 3 keeps the raw xor so stage 4 only has a wide NOR per way
    t_va_tag  s3_xor   [`TLB_WAYS];
    t_way_vec s3_valid;
    t_pa_page s3_pa    [`TLB_WAYS];

    // Stage 4 has one match bit per way
    t_way_vec s4_match;
    t_pa_page s4_pa    [`TLB_WAYS];

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < `TLB_WAYS; w++)
        begin
            s2_rdata[w] <= rdata[w];

            s3_xor[w]   <= s2_rdata[w].tag ^ stg_va[2][`TLB_VA_PAGE_BITS-1:`TLB_IDX_BITS];
            s3_valid[w] <= s2_rdata[w].valid;
            s3_pa[w]    <= s2_rdata[w].pa;

            s4_match[w] <= s3_valid[w] & ~(|s3_xor[w]);
            s4_pa[w]    <= s3_pa[w];
        end
    end

    // Lowest matching way wins, although a well-behaved fill path never
    // leaves two ways of a set with the same tag
    t_way_idx hit_way;

    always_comb
    begin
        hit_way = '0;
        for (int w = `TLB_WAYS-1; w >= 0; w--)
        begin
            if (s4_match[w])
            begin
                hit_way = t_way_idx'(w);
            end
        end
    end

    // ==================================================
    // Result and output stages
    // ==================================================

    logic     s5_hit;
    logic     s5_miss;
    t_pa_page s5_pa;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s5_hit      <= 1'b0;
            s5_miss     <= 1'b0;
            lookup_hit  <= 1'b0;
            lookup_miss <= 1'b0;
        end
        else
        begin
            s5_hit      <= stg_valid[4] & (|s4_match);
            s5_miss     <= stg_valid[4] & ~(|s4_match);
            lookup_hit  <= s5_hit;
            lookup_miss <= s5_miss;
        end
    end

    // Page outputs only mean something alongside their pulse
    always_ff @(posedge clk)
    begin
        s5_pa          <= s4_pa[hit_way];
        lookup_page_pa <= s5_pa;
        lookup_miss_va <= stg_va[5];
    end

endmodule

`default_nettype wire

/* tlb_fill_ctrl.sv */
// Fill FSM that filters duplicates, picks a random victim way and issues the insert
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_fill_ctrl
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic fill_en,
    input  t_va_page  fill_va,
    input  t_pa_page  fill_pa,
    input  wire logic hist_clear,
    output logic      ins_en,
    output t_set_idx  ins_idx,
    output t_va_tag   ins_tag,
    output t_pa_page  ins_pa,
    output t_way_vec  ins_way_vec
);

    t_fill_state state;

    // Fill being worked on, captured in FILL_IDLE
    t_va_page fill_va_q;
    t_pa_page fill_pa_q;

    logic not_duplicate;

    // Set and tag both come from the captured page
    assign ins_idx = fill_va_q[`TLB_IDX_BITS-1:0];
    assign ins_tag = fill_va_q[`TLB_VA_PAGE_BITS-1:`TLB_IDX_BITS];
    assign ins_pa  = fill_pa_q;

    tlb_dup_filter dup_filter
    (
        .clk           (clk),
        .reset         (reset),
        .clear         (hist_clear),
        .check_en      (state == FILL_CHECK_HISTORY),
        .check_idx     (ins_idx),
        .check_tag     (ins_tag),
        .not_duplicate (not_duplicate)
    );

    // ==================================================
    // Random victim selection
    // ==================================================

    // Free-running 8-bit maximal LFSR, taps 8 6 5 4
    logic [7:0] lfsr;
    t_way_idx   victim_idx;

    assign victim_idx = lfsr[`TLB_WAY_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= 8'h01;
        end
        else
        begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // ==================================================
    // Fill FSM
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= FILL_IDLE;
        end
        else
        begin
            case (state)
                FILL_IDLE:
                begin
                    // Fills arriving in any other state are lost
                    if (fill_en)
                    begin
                        state <= FILL_CHECK_HISTORY;
                    end
                end
                FILL_CHECK_HISTORY:
                begin
                    state <= FILL_DROP_DUPS;
                end
                FILL_DROP_DUPS:
                begin
                    // A recent fill already placed this page, so nothing to do
                    state <= not_duplicate ? FILL_PICK_WAY : FILL_IDLE;
                end
                FILL_PICK_WAY:
                begin
                    state <= FILL_INSERT;
                end
                default:
                begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == FILL_IDLE) && fill_en)
        begin
            fill_va_q <= fill_va;
            fill_pa_q <= fill_pa;
        end

        // Victim held steady through FILL_INSERT
        if (state == FILL_PICK_WAY)
        begin
            ins_way_vec <= t_way_vec'(1) << victim_idx;
        end
    end

    // One-cycle insert request to the write arbiter
    assign ins_en = (state == FILL_INSERT);

endmodule

`default_nettype wire

/* tlb_top.sv */
// Translation cache top level, the DUT that connects storage, lookup, fill and maintenance
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb_top
    import tlb_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic lookup_en,
    input  t_va_page  lookup_page_va,
    input  wire logic fill_en,
    input  t_va_page  fill_va,
    input  t_pa_page  fill_pa,
    input  wire logic flush_tlb,
    input  wire logic inval_page_en,
    input  t_va_page  inval_page_va,
    output logic      lookup_ready,
    output logic      lookup_hit,
    output logic      lookup_miss,
    output t_pa_page  lookup_page_pa,
    output t_va_page  lookup_miss_va
);

    // Shared write port, driven by the maintenance block
    t_set_idx   waddr;
    t_tlb_entry wdata;
    t_way_vec   wen;

    t_tlb_entry way_rdata [`TLB_WAYS];

    // Insert request from the fill path
    logic     ins_en;
    t_set_idx ins_idx;
    t_va_tag  ins_tag;
    t_pa_page ins_pa;
    t_way_vec ins_way_vec;

    logic hist_clear;

    // ==================================================
    // Storage, one memory per way
    // ==================================================

    for (genvar w = 0; w < `TLB_WAYS; w++)
    begin : g_way
        tlb_way_ram way_ram
        (
            .clk   (clk),
            .waddr (waddr),
            .wen   (wen[w]),
            .wdata (wdata),
            .raddr (lookup_page_va[`TLB_IDX_BITS-1:0]),
            .rdata (way_rdata[w])
        );
    end

    tlb_maint maint
    (
        .clk           (clk),
        .reset         (reset),
        .flush_tlb     (flush_tlb),
        .inval_page_en (inval_page_en),
        .inval_page_va (inval_page_va),
        .ins_en        (ins_en),
        .ins_idx       (ins_idx),
        .ins_tag       (ins_tag),
        .ins_pa        (ins_pa),
        .ins_way_vec   (ins_way_vec),
        .lookup_ready  (lookup_ready),
        .hist_clear    (hist_clear),
        .waddr         (waddr),
        .wdata         (wdata),
        .wen           (wen)
    );

    tlb_lookup_pipe lookup_pipe
    (
        .clk            (clk),
        .reset          (reset),
        .lookup_en      (lookup_en),
        .lookup_page_va (lookup_page_va),
        .rdata          (way_rdata),
        .lookup_hit     (lookup_hit),
        .lookup_miss    (lookup_miss),
        .lookup_page_pa (lookup_page_pa),
        .lookup_miss_va (lookup_miss_va)
    );

    tlb_fill_ctrl fill_ctrl
    (
        .clk         (clk),
        .reset       (reset),
        .fill_en     (fill_en),
        .fill_va     (fill_va),
        .fill_pa     (fill_pa),
        .hist_clear  (hist_clear),
        .ins_en      (ins_en),
        .ins_idx     (ins_idx),
        .ins_tag     (ins_tag),
        .ins_pa      (ins_pa),
        .ins_way_vec (ins_way_vec)
    );

endmodule

`default_nettype wire

/* tb_tlb_tests.svh */
// Directed tests of the translation cache, included inside the testbench module

// ==================================================
// Reset and fill tests
// ==================================================

// Everything misses once the reset sweep is over
task automatic test_reset_miss();
    int i;
    wait_ready(1'b1, `TLB_SETS + 8, "the reset sweep");
    for (i = 0; i < 6; i++)
    begin
        expect_lookup(t_va_page'(rand_bits(`TLB_VA_PAGE_BITS)), 1'b0, '0);
    end
    run_lookups("reset_miss");
endtask

// Sets 1 to 8 each get one translation, so no victim can evict another
task automatic test_fill_hit();
    int i;
    t_va_page va;
    t_pa_page pa;
    for (i = 0; i < 8; i++)
    begin
        va = page_in_set(t_set_idx'(i + 1));
        pa = rand_pa();
        fill_page(va, pa);
        ref_va.push_back(va);
        ref_pa.push_back(pa);
        filled_va.push_back(va);
    end
    for (i = 0; i < ref_va.size(); i++)
    begin
        expect_lookup(ref_va[i], 1'b1, ref_pa[i]);
    end
    run_lookups("fill_hit");
endtask

// The second fill of a page still in the history is dropped
task automatic test_dup_fill();
    t_va_page va;
    t_pa_page pa1;
    va  = page_in_set(t_set_idx'(40));
    pa1 = rand_pa();
    fill_page(va, pa1);
    fill_page(va, ~pa1);
    ref_va.push_back(va);
    ref_pa.push_back(pa1);
    filled_va.push_back(va);
    expect_lookup(va, 1'b1, pa1);
    run_lookups("dup_fill");
endtask

// ==================================================
// Maintenance tests
// ==================================================

// A second page shares the set of the invalidated one and must go too
task automatic test_inval_page();
    int i;
    t_va_page target;
    t_va_page other;
    t_set_idx idx;
    target = ref_va[0];
    idx    = target[`TLB_IDX_BITS-1:0];
    other  = page_in_set(idx);
    if (other == target)
    begin
        other[`TLB_VA_PAGE_BITS-1] = ~other[`TLB_VA_PAGE_BITS-1];
    end
    fill_page(other, rand_pa());
    filled_va.push_back(other);

    inval_page_en = 1'b1;
    inval_page_va = target;
    step();
    inval_page_en = 1'b0;
    repeat (2) step();

    for (i = ref_va.size() - 1; i >= 0; i--)
    begin
        if (ref_va[i][`TLB_IDX_BITS-1:0] == idx)
        begin
            ref_va.delete(i);
            ref_pa.delete(i);
        end
    end
    expect_lookup(target, 1'b0, '0);
    expect_lookup(other, 1'b0, '0);
    for (i = 0; i < ref_va.size(); i++)
    begin
        expect_lookup(ref_va[i], 1'b1, ref_pa[i]);
    end
    run_lookups("inval_page");
endtask

// The page filled just before the flush sits in the history, so the
// refill only lands if the flush cleared it
task automatic test_flush();
    int i;
    t_va_page va;
    t_pa_page pa;
    va = page_in_set(t_set_idx'(50));
    fill_page(va, rand_pa());
    filled_va.push_back(va);

    flush_tlb = 1'b1;
    step();
    flush_tlb = 1'b0;
    wait_ready(1'b0, `TLB_FLUSH_DELAY, "the flush start");
    wait_ready(1'b1, `TLB_SETS + 4, "the flush sweep");
    ref_va.delete();
    ref_pa.delete();

    for (i = 0; i < filled_va.size(); i++)
    begin
        expect_lookup(filled_va[i], 1'b0, '0);
    end
    run_lookups("flush_miss");

    pa = rand_pa();
    fill_page(va, pa);
    expect_lookup(va, 1'b1, pa);
    run_lookups("flush_refill");
endtask

/* tb_tlb.sv */
// Testbench top for the translation cache, run through filelist.f by run_sim.sh
`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tb_tlb
    import tlb_pkg::*;
;

    // Five directed tests, each given a sweep's worth of cycles plus margin
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (`TLB_SETS + 200);

    logic     clk;
    logic     reset;
    logic     lookup_en;
    t_va_page lookup_page_va;
    logic     fill_en;
    t_va_page fill_va;
    t_pa_page fill_pa;
    logic     flush_tlb;
    logic     inval_page_en;
    t_va_page inval_page_va;
    logic     lookup_ready;
    logic     lookup_hit;
    logic     lookup_miss;
    t_pa_page lookup_page_pa;
    t_va_page lookup_miss_va;

    int check_count;
    int error_count;
    int cycle_count;

    // Galois LFSR state for all random page numbers
    logic [31:0] lfsr_state = 32'h6fba;

    // Translations that should be in the cache right now
    t_va_page ref_va [$];
    t_pa_page ref_pa [$];

    // Every page ever filled, all of which a flush must remove
    t_va_page filled_va [$];

    // Pending lookup batch with its expected answers
    t_va_page lk_va  [$];
    logic     lk_hit [$];
    t_pa_page lk_pa  [$];

    tlb_top UUT
    (
        .clk            (clk),
        .reset          (reset),
        .lookup_en      (lookup_en),
        .lookup_page_va (lookup_page_va),
        .fill_en        (fill_en),
        .fill_va        (fill_va),
        .fill_pa        (fill_pa),
        .flush_tlb      (flush_tlb),
        .inval_page_en  (inval_page_en),
        .inval_page_va  (inval_page_va),
        .lookup_ready   (lookup_ready),
        .lookup_hit     (lookup_hit),
        .lookup_miss    (lookup_miss),
        .lookup_page_pa (lookup_page_pa),
        .lookup_miss_va (lookup_miss_va)
    );

    always #5 clk = ~clk;

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Inputs change 1 ns after a rising edge, where outputs are also stable
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
        begin
            lfsr_state ^= 32'h80200003;
        end
        return lsb;
    endfunction

    // One LFSR step for each bit of the result
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            value = {value[30:0], rand_bit()};
        end
        return value;
    endfunction

    // Random tag placed in a chosen set
    function automatic t_va_page page_in_set(input t_set_idx idx);
        return {t_va_tag'(rand_bits(`TLB_TAG_BITS)), idx};
    endfunction

    function automatic t_pa_page rand_pa();
        return t_pa_page'(rand_bits(`TLB_PA_PAGE_BITS));
    endfunction

    // One fill pulse, then enough idle cycles for the insert to land
    task automatic fill_page(input t_va_page va, input t_pa_page pa);
        fill_en = 1'b1;
        fill_va = va;
        fill_pa = pa;
        step();
        fill_en = 1'b0;
        repeat (8) step();
    endtask

    task automatic expect_lookup(input t_va_page va, input logic hit, input t_pa_page pa);
        lk_va.push_back(va);
        lk_hit.push_back(hit);
        lk_pa.push_back(pa);
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_pa(input string name, input t_pa_page exp, input t_pa_page act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_va(input string name, input t_va_page exp, input t_va_page act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Polls lookup_ready once per cycle up to a bound
    task automatic wait_ready(input logic level, input int max_cycles, input string what);
        int waited;
        waited = 0;
        while (lookup_ready !== level && waited < max_cycles)
        begin
            step();
            waited++;
        end
        check_count++;
        if (lookup_ready !== level)
        begin
            error_count++;
            $display("lookup_ready did not go %s during %s within %0d cycles",
                     level ? "high" : "low", what, max_cycles);
        end
    endtask

    // Issues the queued lookups back to back. The answer to lookup j must
    // show up exactly TLB_LOOKUP_LATENCY edges after it was sampled, and
    // no pulse may appear in any other cycle of the batch
    task automatic run_lookups(input string name);
        int n;
        int c;
        int j;
        n = lk_va.size();
        for (c = 0; c <= n + `TLB_LOOKUP_LATENCY; c++)
        begin
            lookup_en = (c < n);
            if (c < n)
            begin
                lookup_page_va = lk_va[c];
            end
            j = c - `TLB_LOOKUP_LATENCY - 1;
            if (j < 0)
            begin
                check_bit($sformatf("%s idle hit", name), 1'b0, lookup_hit);
                check_bit($sformatf("%s idle miss", name), 1'b0, lookup_miss);
            end
            else
            begin
                check_bit($sformatf("%s lookup %0d hit", name, j), lk_hit[j], lookup_hit);
                check_bit($sformatf("%s lookup %0d miss", name, j), !lk_hit[j], lookup_miss);
                if (lk_hit[j])
                begin
                    check_pa($sformatf("%s lookup %0d pa", name, j), lk_pa[j], lookup_page_pa);
                end
                else
                begin
                    check_va($sformatf("%s lookup %0d miss va", name, j), lk_va[j],
                             lookup_miss_va);
                end
            end
            step();
        end
        lk_va.delete();
        lk_hit.delete();
        lk_pa.delete();
    endtask

    `include "tb_tlb_tests.svh"

    // ==================================================
    // Run control
    // ==================================================

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d clock cycles without finishing the tests",
                 TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        lookup_en      = 1'b0;
        lookup_page_va = '0;
        fill_en        = 1'b0;
        fill_va        = '0;
        fill_pa        = '0;
        flush_tlb      = 1'b0;
        inval_page_en  = 1'b0;
        inval_page_va  = '0;
        check_count    = 0;
        error_count    = 0;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_miss();
        test_fill_hit();
        test_dup_fill();
        test_inval_page();
        test_flush();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
tlb_pkg.sv
tlb_way_ram.sv
tlb_dup_filter.sv
tlb_maint.sv
tlb_lookup_pipe.sv
tlb_fill_ctrl.sv
tlb_top.sv
tb_tlb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the translation cache testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_tlb -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_tlb)"
echo "$sim_out"

echo "$sim_out" | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1
